// ==== hw/sd_card_config.svh ====
// card constants shared by packages and modules; only the 4-byte NCR gap and 512-byte sectors are supported
`ifndef SD_CARD_CONFIG_SVH
`define SD_CARD_CONFIG_SVH

// fill bytes between the command CRC byte and R1
`define SD_NCR 4

// one sector, also the only legal CMD16 length
`define SD_SECTOR_BYTES 512

// buffer index width, log2 of the sector length
`define SD_BUF_AW 9

// start token for a single block, both directions
`define SD_TOKEN_START 8'hFE

// data response "accepted"
`define SD_DATA_RESP_OK 8'h05

// idle level on the bus, all ones
`define SD_FILL 8'hFF

`endif

// ==== hw/sd_proto_pkg.sv ====
// SPI-mode protocol types; only the command indices the card answers are named in the enum
package sd_proto_pkg;

    // one byte on the SPI wire
    typedef logic [7:0] sd_byte_t;

    // 32-bit command argument, MSB received first
    typedef logic [31:0] sd_arg_t;

    // command index, low 6 bits of the start byte
    typedef enum logic [5:0] {
        GO_IDLE         = 6'd0,   // CMD0
        SEND_IF_COND    = 6'd8,   // CMD8
        SEND_STATUS     = 6'd13,  // CMD13
        SET_BLOCKLEN    = 6'd16,  // CMD16
        READ_SINGLE     = 6'd17,  // CMD17
        WRITE_SINGLE    = 6'd24,  // CMD24
        SD_SEND_OP_COND = 6'd41,  // ACMD41 when after CMD55
        APP_CMD         = 6'd55,  // CMD55
        READ_OCR        = 6'd58   // CMD58
    } sd_cmd_e;

    // R1 codes
    localparam sd_byte_t R1_READY   = 8'h00;
    localparam sd_byte_t R1_IDLE    = 8'h01;  // idle bit
    localparam sd_byte_t R1_ILLEGAL = 8'h04;  // illegal command bit
    localparam sd_byte_t R1_PARAM   = 8'h40;  // parameter error bit

    // data phase states, shared by read and write
    typedef enum logic [2:0] {
        X_IDLE,   // command engine owns sdo
        X_REQ,    // host request pending
        X_WAIT,   // accepted, waiting for req_done
        X_SYNC,   // done seen, wait for byte boundary
        X_TOKEN,  // read sends token, write hunts for it
        X_DATA,   // 512 data bytes
        X_CRC,    // two CRC bytes, never checked
        X_DRESP   // write data response
    } xfer_state_e;

endpackage

// ==== hw/sd_host_pkg.sv ====
// host-side types; the buffer index covers exactly one sector
`include "sd_card_config.svh"

package sd_host_pkg;

    // sector number handed to the host
    typedef logic [31:0] sd_lba_t;

    // byte index into the sector buffer
    typedef logic [`SD_BUF_AW-1:0] buf_addr_t;

endpackage

// ==== hw/sd_spi_link.sv ====
// SPI mode 0 byte link; needs sck at 8 or more clk_sys cycles per period, first byte after cs goes out as 0xFF
`timescale 1ns/1ps
`include "sd_card_config.svh"

module sd_spi_link
    import sd_proto_pkg::*;
(
    input  logic     clk_sys,
    input  logic     card_is_reset,
    input  logic     sd_cs,
    input  logic     sd_sck,
    input  logic     sd_sdi,
    input  sd_byte_t tx_byte,
    output logic     sd_sdo,
    output sd_byte_t rx_byte,
    output logic     rx_valid,
    output logic     selected
);

    logic [2:0] sck_q;  // two sync stages plus edge history
    logic [1:0] sdi_q;  // same depth as sck, keeps bits aligned
    logic [1:0] cs_q;
    logic [2:0] bit_cnt;
    sd_byte_t   rx_sh;
    sd_byte_t   tx_sh;
    logic       sck_rise;
    logic       sck_fall;

    always_ff @(posedge clk_sys) begin
        sck_q <= {sck_q[1:0], sd_sck};
        sdi_q <= {sdi_q[0], sd_sdi};
        cs_q  <= {cs_q[0], sd_cs};
    end

    assign sck_rise = sck_q[1] & ~sck_q[2];
    assign sck_fall = ~sck_q[1] & sck_q[2];
    assign selected = ~cs_q[1];  // cs active low
    assign rx_byte  = rx_sh;

    // receive shifter, sampled on rising sck
    always_ff @(posedge clk_sys) begin
        if (selected && sck_rise) rx_sh <= {rx_sh[6:0], sdi_q[1]};
    end

    always_ff @(posedge clk_sys) begin
        rx_valid <= 1'b0;
        if (card_is_reset || !selected) begin
            bit_cnt <= 3'd0;   // next byte starts clean
            sd_sdo  <= 1'b1;
            tx_sh   <= `SD_FILL;
        end else begin
            if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) rx_valid <= 1'b1;  // rx_sh complete next cycle
            end
            if (sck_fall) begin
                if (bit_cnt == 3'd0) begin
                    // byte boundary, take a new byte MSB first
                    sd_sdo <= tx_byte[7];
                    tx_sh  <= {tx_byte[6:0], 1'b1};
                end else begin
                    sd_sdo <= tx_sh[7];
                    tx_sh  <= {tx_sh[6:0], 1'b1};  // shift in ones
                end
            end
        end
    end

endmodule

// ==== hw/sd_card_regs.sv ====
// card state and argument register; LBA is arg/512 for SDSC, arg itself for SDHC
`timescale 1ns/1ps
`include "sd_card_config.svh"

module sd_card_regs
    import sd_proto_pkg::*;
    import sd_host_pkg::*;
(
    input  logic        clk_sys,
    input  logic        card_is_reset,
    input  logic        arg_load,
    input  sd_arg_t     arg_in,
    input  logic        go_idle,
    input  logic        app_set,
    input  logic        app_clear,
    input  logic        sdhc_mode,
    output sd_arg_t     arg,
    output logic        initialized,
    output logic        app_pending,
    output sd_lba_t     lba,
    output logic [31:0] ocr
);

    always_ff @(posedge clk_sys) begin
        if (card_is_reset) begin
            initialized <= 1'b0;
            app_pending <= 1'b0;
        end else begin
            if (go_idle) initialized <= 1'b1;  // sticky until reset
            if (app_set)
                app_pending <= 1'b1;
            else if (app_clear)
                app_pending <= 1'b0;  // any other command ends the CMD55 window
        end
    end

    // argument shifts in one byte per load
    always_ff @(posedge clk_sys) begin
        if (arg_load) arg <= arg_in;
    end

    // byte address to sector for SDSC
    assign lba = sdhc_mode ? sd_lba_t'(arg) : sd_lba_t'(arg >> `SD_BUF_AW);

    // power-up done, CCS, 2.7-3.6 V window
    assign ocr = {1'b1, sdhc_mode, 6'd0, 9'h1FF, 15'd0};

endmodule

// ==== hw/sd_cmd_engine.sv ====
// command framer and R1/R3/R7 sequencer; bytes that arrive during a reply or a data phase are dropped
`timescale 1ns/1ps
`include "sd_card_config.svh"

module sd_cmd_engine
    import sd_proto_pkg::*;
(
    input  logic        clk_sys,
    input  logic        card_is_reset,
    input  sd_byte_t    rx_byte,
    input  logic        rx_valid,
    input  logic        selected,
    input  logic        xfer_busy,
    input  sd_arg_t     arg,
    input  logic        initialized,
    input  logic        app_pending,
    input  logic [31:0] ocr,
    output logic        arg_load,
    output sd_arg_t     arg_in,
    output logic        go_idle,
    output logic        app_set,
    output logic        app_clear,
    output logic        xfer_start,
    output logic        xfer_write,
    output sd_byte_t    cmd_tx_byte
);

    localparam logic [3:0] R1_POS = 4'(`SD_NCR + 1);  // R1 slot after the CRC byte

    logic        in_cmd;
    logic        in_reply;
    logic [2:0]  cmd_cnt;   // 0..3 arg bytes, 4 is CRC
    logic [3:0]  rpos;      // reply byte on the wire
    logic [3:0]  next_pos;
    sd_cmd_e     cmd_idx;
    sd_byte_t    r1;
    logic [31:0] ext;       // extra reply bytes, MSB first
    logic [2:0]  ext_len;
    logic        is_xfer;
    sd_byte_t    dec_r1;
    logic [31:0] dec_ext;
    logic [2:0]  dec_len;
    logic        dec_xfer;
    logic        take;
    logic        crc_byte;

    assign take       = rx_valid && selected && !xfer_busy;
    assign crc_byte   = take && in_cmd && cmd_cnt == 3'd4;
    assign arg_load   = take && in_cmd && cmd_cnt != 3'd4;
    assign arg_in     = {arg[23:0], rx_byte};
    assign go_idle    = crc_byte && cmd_idx == GO_IDLE;
    assign app_set    = crc_byte && initialized && cmd_idx == APP_CMD;
    assign app_clear  = crc_byte && !app_set;
    assign next_pos   = rpos + 4'd1;
    assign xfer_start = take && in_reply && rpos == R1_POS && is_xfer;  // R1 just went out

    // reply decode, arg is complete by the CRC byte
    always_comb begin
        dec_r1   = R1_ILLEGAL;
        dec_ext  = 32'd0;
        dec_len  = 3'd0;
        dec_xfer = 1'b0;
        if (cmd_idx == GO_IDLE) begin
            dec_r1 = R1_IDLE;
        end else if (initialized) begin
            case (cmd_idx)
                SEND_IF_COND: begin
                    dec_r1  = R1_IDLE;
                    dec_ext = {16'd0, 4'd0, arg[11:8], arg[7:0]};  // voltage echo, check byte
                    dec_len = 3'd4;
                end
                SEND_STATUS: begin
                    dec_r1  = R1_READY;
                    dec_len = 3'd1;  // second status byte 00
                end
                SET_BLOCKLEN:
                    dec_r1 = (arg == sd_arg_t'(`SD_SECTOR_BYTES)) ? R1_READY : R1_PARAM;
                READ_SINGLE, WRITE_SINGLE: begin
                    dec_r1   = R1_READY;
                    dec_xfer = 1'b1;
                end
                APP_CMD:         dec_r1 = R1_IDLE;
                SD_SEND_OP_COND: dec_r1 = app_pending ? R1_READY : R1_ILLEGAL;
                READ_OCR: begin
                    dec_r1  = R1_READY;
                    dec_ext = ocr;  // R3
                    dec_len = 3'd4;
                end
                default: dec_r1 = R1_ILLEGAL;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (card_is_reset || !selected) begin
            in_cmd      <= 1'b0;
            in_reply    <= 1'b0;
            cmd_cnt     <= 3'd0;
            rpos        <= 4'd0;
            cmd_tx_byte <= `SD_FILL;
        end else if (take) begin
            if (in_reply) begin
                rpos        <= next_pos;
                cmd_tx_byte <= `SD_FILL;  // NCR gap and tail
                if (rpos == R1_POS + 4'(ext_len))
                    in_reply <= 1'b0;  // last reply byte done
                else if (next_pos == R1_POS)
                    cmd_tx_byte <= r1;
                else if (next_pos > R1_POS)
                    cmd_tx_byte <= ext[31:24];
            end else if (in_cmd) begin
                cmd_cnt <= cmd_cnt + 3'd1;
                if (crc_byte) begin
                    in_cmd   <= 1'b0;
                    in_reply <= 1'b1;
                    rpos     <= 4'd1;  // first fill byte
                end
            end else if (rx_byte[7:6] == 2'b01) begin
                in_cmd  <= 1'b1;  // start byte
                cmd_cnt <= 3'd0;
            end
        end
    end

    // decoded reply, held until the reply ends
    always_ff @(posedge clk_sys) begin
        if (take && !in_cmd && !in_reply) cmd_idx <= sd_cmd_e'(rx_byte[5:0]);
        if (crc_byte) begin
            r1         <= dec_r1;
            ext        <= dec_ext;
            ext_len    <= dec_len;
            is_xfer    <= dec_xfer;
            xfer_write <= cmd_idx == WRITE_SINGLE;
        end else if (take && in_reply && next_pos > R1_POS) begin
            ext <= {ext[23:0], 8'h00};  // next extra byte to top
        end
    end

endmodule

// ==== hw/sd_block_xfer.sv ====
// single-block data phases; an accepted host request always runs to req_done, even after cs rises
`timescale 1ns/1ps
`include "sd_card_config.svh"

module sd_block_xfer
    import sd_proto_pkg::*;
    import sd_host_pkg::*;
(
    input  logic      clk_sys,
    input  logic      card_is_reset,
    input  sd_byte_t  rx_byte,
    input  logic      rx_valid,
    input  logic      selected,
    input  logic      xfer_start,
    input  logic      xfer_write,
    input  sd_lba_t   lba,
    input  sd_byte_t  cmd_tx_byte,
    output sd_byte_t  tx_byte,
    output logic      xfer_busy,
    output logic      req_valid,
    output logic      req_write,
    output sd_lba_t   req_lba,
    input  logic      req_ready,
    input  logic      req_done,
    output buf_addr_t buf_addr,
    output sd_byte_t  buf_wdata,
    output logic      buf_we,
    input  sd_byte_t  buf_rdata
);

    localparam buf_addr_t LAST = buf_addr_t'(`SD_SECTOR_BYTES - 1);

    xfer_state_e state;
    buf_addr_t   ptr;      // also prefetch address on reads
    logic        crc_cnt;  // second CRC byte

    assign xfer_busy = state != X_IDLE;
    assign req_valid = state == X_REQ;
    assign buf_addr  = ptr;
    assign buf_wdata = rx_byte;
    assign buf_we    = state == X_DATA && req_write && rx_valid && selected;

    always_ff @(posedge clk_sys) begin
        if (card_is_reset) begin
            state     <= X_IDLE;
            ptr       <= '0;
            crc_cnt   <= 1'b0;
            req_write <= 1'b0;
        end else begin
            case (state)
                X_IDLE: if (xfer_start) begin
                    state     <= xfer_write ? X_TOKEN : X_REQ;  // write takes data first
                    req_write <= xfer_write;
                    ptr       <= '0;
                    crc_cnt   <= 1'b0;
                end
                X_REQ:
                    if (!selected) state <= X_IDLE;  // not yet accepted, drop it
                    else if (req_ready) state <= X_WAIT;
                X_WAIT: if (req_done) state <= X_SYNC;  // runs on without cs
                X_SYNC:
                    if (!selected) state <= X_IDLE;
                    else if (rx_valid) state <= req_write ? X_IDLE : X_TOKEN;
                X_TOKEN:
                    if (!selected) state <= X_IDLE;
                    else if (rx_valid && (!req_write || rx_byte == `SD_TOKEN_START))
                        state <= X_DATA;
                X_DATA:
                    if (!selected) state <= X_IDLE;
                    else if (rx_valid) begin
                        ptr <= ptr + 1'b1;
                        if (ptr == LAST) state <= X_CRC;
                    end
                X_CRC:
                    if (!selected) state <= X_IDLE;
                    else if (rx_valid) begin
                        crc_cnt <= ~crc_cnt;
                        if (crc_cnt) state <= req_write ? X_DRESP : X_IDLE;
                    end
                X_DRESP:
                    if (!selected) state <= X_IDLE;
                    else if (rx_valid) state <= X_REQ;  // buffer full, hand to host
                default: state <= X_IDLE;
            endcase
        end
    end

    // sector number fixed for the whole transfer
    always_ff @(posedge clk_sys) begin
        if (state == X_IDLE && xfer_start) req_lba <= lba;
    end

    // byte for the next boundary
    always_comb begin
        case (state)
            X_IDLE:                tx_byte = cmd_tx_byte;
            X_TOKEN:               tx_byte = req_write ? `SD_FILL : `SD_TOKEN_START;
            X_DATA:                tx_byte = req_write ? `SD_FILL : buf_rdata;
            X_DRESP:               tx_byte = `SD_DATA_RESP_OK;
            X_REQ, X_WAIT, X_SYNC: tx_byte = req_write ? 8'h00 : `SD_FILL;  // write busy low
            default:               tx_byte = `SD_FILL;
        endcase
    end

endmodule

// ==== hw/sd_sector_buffer.sv ====
// one-sector true dual-port RAM; same-address writes from both ports in one cycle are not resolved
`timescale 1ns/1ps
`include "sd_card_config.svh"

module sd_sector_buffer
    import sd_proto_pkg::*;
    import sd_host_pkg::*;
(
    input  logic      clk_sys,
    input  buf_addr_t card_addr,
    input  sd_byte_t  card_wdata,
    input  logic      card_we,
    output sd_byte_t  card_rdata,
    input  buf_addr_t host_addr,
    input  sd_byte_t  host_wdata,
    input  logic      host_we,
    output sd_byte_t  host_rdata
);

    sd_byte_t mem [0:`SD_SECTOR_BYTES-1];

    // both ports in one process, reads return old data
    always_ff @(posedge clk_sys) begin
        if (card_we) mem[card_addr] <= card_wdata;
        if (host_we) mem[host_addr] <= host_wdata;
        card_rdata <= mem[card_addr];
        host_rdata <= mem[host_addr];  // one cycle after host_addr
    end

endmodule

// ==== hw/sd_card_top.sv ====
// SPI-mode SD card top; single-block only, card type taken from sdhc_mode
`timescale 1ns/1ps
`include "sd_card_config.svh"

module sd_card_top (
    input  logic                  clk_sys,
    input  logic                  card_is_reset,
    input  logic                  sd_cs,
    input  logic                  sd_sck,
    input  logic                  sd_sdi,
    output logic                  sd_sdo,
    output logic                  req_valid,
    output logic                  req_write,
    output logic [31:0]           req_lba,
    input  logic                  req_ready,
    input  logic                  req_done,
    input  logic [`SD_BUF_AW-1:0] host_addr,
    input  logic [7:0]            host_wdata,
    input  logic                  host_we,
    output logic [7:0]            host_rdata,
    input  logic                  sdhc_mode
);

    logic [7:0]            rx_byte;
    logic                  rx_valid;
    logic                  selected;
    logic [7:0]            tx_byte;
    logic [7:0]            cmd_tx_byte;
    logic [31:0]           arg;
    logic [31:0]           arg_in;
    logic                  arg_load;
    logic                  go_idle;
    logic                  app_set;
    logic                  app_clear;
    logic                  initialized;
    logic                  app_pending;
    logic [31:0]           lba;
    logic [31:0]           ocr;
    logic                  xfer_start;
    logic                  xfer_write;
    logic                  xfer_busy;
    logic [`SD_BUF_AW-1:0] buf_addr;
    logic [7:0]            buf_wdata;
    logic                  buf_we;
    logic [7:0]            buf_rdata;

    sd_spi_link link_i (
        .clk_sys, .card_is_reset, .sd_cs, .sd_sck, .sd_sdi, .tx_byte,
        .sd_sdo, .rx_byte, .rx_valid, .selected
    );

    sd_card_regs regs_i (
        .clk_sys, .card_is_reset, .arg_load, .arg_in, .go_idle, .app_set, .app_clear,
        .sdhc_mode, .arg, .initialized, .app_pending, .lba, .ocr
    );

    sd_cmd_engine cmd_i (
        .clk_sys, .card_is_reset, .rx_byte, .rx_valid, .selected, .xfer_busy,
        .arg, .initialized, .app_pending, .ocr, .arg_load, .arg_in, .go_idle,
        .app_set, .app_clear, .xfer_start, .xfer_write, .cmd_tx_byte
    );

    sd_block_xfer xfer_i (
        .clk_sys, .card_is_reset, .rx_byte, .rx_valid, .selected, .xfer_start,
        .xfer_write, .lba, .cmd_tx_byte, .tx_byte, .xfer_busy, .req_valid,
        .req_write, .req_lba, .req_ready, .req_done, .buf_addr, .buf_wdata,
        .buf_we, .buf_rdata
    );

    sd_sector_buffer buf_i (
        .clk_sys,
        .card_addr  (buf_addr),
        .card_wdata (buf_wdata),
        .card_we    (buf_we),
        .card_rdata (buf_rdata),
        .host_addr, .host_wdata, .host_we, .host_rdata
    );

endmodule

// ==== dv/sd_card_props.sv ====
// host handshake checks on the card top; assumes cs stays low while a request is pending
`timescale 1ns/1ps

module sd_card_props (
    input logic        clk_sys,
    input logic        card_is_reset,
    input logic        req_valid,
    input logic        req_write,
    input logic [31:0] req_lba,
    input logic        req_ready,
    input logic        req_done
);

    logic accepted;  // between handshake and req_done

    always_ff @(posedge clk_sys) begin
        if (card_is_reset) accepted <= 1'b0;
        else if (req_valid && req_ready) accepted <= 1'b1;
        else if (req_done) accepted <= 1'b0;
    end

    hold_stable: assert property (@(posedge clk_sys) disable iff (card_is_reset)
        req_valid && !req_ready |=> req_valid && $stable(req_write) && $stable(req_lba))
        else $error("request changed while waiting for req_ready");

    low_after_reset: assert property (@(posedge clk_sys) $fell(card_is_reset) |-> !req_valid)
        else $error("req_valid high right after reset");

    one_outstanding: assert property (@(posedge clk_sys) disable iff (card_is_reset)
        accepted |-> !req_valid)
        else $error("new request before req_done");

endmodule

bind sd_card_top sd_card_props props_i (.*);

// ==== dv/sd_card_tb.sv ====
// SD SPI card testbench; SPI mode 0 at 8 clk_sys per sck, every failure ends the run with $fatal
`timescale 1ns/1ps
`include "sd_card_config.svh"

module sd_card_tb
    import sd_proto_pkg::*;
    import sd_host_pkg::*;
;

    logic      clk_sys = 1'b0;
    logic      card_is_reset;
    logic      sd_cs, sd_sck, sd_sdi, sd_sdo;
    logic      req_valid, req_write, req_ready, req_done;
    sd_lba_t   req_lba;
    buf_addr_t host_addr;
    sd_byte_t  host_wdata, host_rdata;
    logic      host_we, sdhc_mode;

    logic [31:0] rng = 32'hbb2aabc2;
    sd_byte_t    sector [0:`SD_SECTOR_BYTES-1];  // expected sector contents
    sd_lba_t     exp_lba;
    logic        exp_write;
    logic        model_init = 1'b0;  // CMD0 seen
    logic        model_app = 1'b0;   // last command was an accepted CMD55

    sd_card_top dut_i (.*);

    always #2 clk_sys = ~clk_sys;  // 4 ns

    function automatic logic [31:0] xorshift(logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // {extra length, R1, extra bytes MSB first}
    function automatic logic [42:0] sd_expect_reply(sd_cmd_e cmd, sd_arg_t arg, logic was_init,
                                                    logic after_app, logic sdhc);
        sd_byte_t    r1;
        logic [31:0] extra;
        logic [2:0]  len;
        r1 = R1_ILLEGAL;
        extra = 32'd0;
        len = 3'd0;
        if (cmd == GO_IDLE) r1 = R1_IDLE;  // always legal
        else if (was_init) begin
            case (cmd)
                SEND_IF_COND: begin
                    r1 = R1_IDLE;
                    extra = {20'd0, arg[11:8], arg[7:0]};  // R7 echo
                    len = 3'd4;
                end
                SEND_STATUS: begin
                    r1 = R1_READY;
                    len = 3'd1;
                end
                SET_BLOCKLEN: r1 = (arg == 32'd512) ? R1_READY : R1_PARAM;
                READ_SINGLE, WRITE_SINGLE: r1 = R1_READY;
                APP_CMD: r1 = R1_IDLE;
                SD_SEND_OP_COND: r1 = after_app ? R1_READY : R1_ILLEGAL;
                READ_OCR: begin
                    r1 = R1_READY;
                    extra = 32'h80FF8000 | {1'b0, sdhc, 30'd0};  // busy done, CCS, 2.7-3.6 V
                    len = 3'd4;
                end
                default: r1 = R1_ILLEGAL;
            endcase
        end
        return {len, r1, extra};
    endfunction

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_problem(string what);
        $display("at %0t ns: %s", $time, what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(string name, sd_byte_t got, sd_byte_t exp);
        if (got !== exp) report_mismatch(name, {24'd0, got}, {24'd0, exp});
    endtask

    task automatic check_r1(string cmd_name, sd_byte_t got, sd_byte_t exp);
        if (got !== exp) report_mismatch({"R1 of ", cmd_name}, {24'd0, got}, {24'd0, exp});
    endtask

    task automatic check_lba(sd_lba_t got, sd_lba_t exp);
        if (got !== exp) report_mismatch("req_lba", got, exp);
    endtask

    // one byte both ways, sample sdo just before each rising sck
    task automatic spi_byte(input sd_byte_t tx, output sd_byte_t rx);
        for (int b = 7; b >= 0; b--) begin
            @(posedge clk_sys);
            sd_sck <= 1'b0;
            sd_sdi <= tx[b];
            repeat (3) @(posedge clk_sys);
            @(posedge clk_sys);
            rx[b] = sd_sdo;
            sd_sck <= 1'b1;
            repeat (3) @(posedge clk_sys);
        end
    endtask

    task automatic run_cmd(input sd_cmd_e cmd, input sd_arg_t arg, input string name);
        logic [42:0] exp;
        sd_byte_t    b;
        int          n;
        exp = sd_expect_reply(cmd, arg, model_init, model_app, sdhc_mode);
        spi_byte({2'b01, cmd}, b);
        for (int k = 3; k >= 0; k--) spi_byte(arg[k*8 +: 8], b);
        spi_byte(8'h95, b);  // crc, ignored by the card
        n = 0;
        spi_byte(`SD_FILL, b);
        while (b == `SD_FILL) begin  // NCR gap
            n++;
            if (n >= `SD_NCR + 2) report_problem({"no R1 after ", name});
            spi_byte(`SD_FILL, b);
        end
        check_r1(name, b, exp[39:32]);
        for (int k = 0; k < int'(exp[42:40]); k++) begin
            spi_byte(`SD_FILL, b);
            check_byte({name, " reply byte"}, b, exp[31-8*k -: 8]);
        end
        model_app = model_init && cmd == APP_CMD;
        if (cmd == GO_IDLE) model_init = 1'b1;
    endtask

    // host side of one request, fills or reads back the buffer
    task automatic host_serve(input int max_delay);
        int n;
        n = 0;
        while (!req_valid) begin
            @(posedge clk_sys);
            n++;
            if (n > 100000) report_problem("host request never raised");
        end
        rng = xorshift(rng);
        repeat (int'(rng % 32'(max_delay + 1))) @(posedge clk_sys);  // back-pressure
        @(posedge clk_sys) req_ready <= 1'b1;
        @(posedge clk_sys) req_ready <= 1'b0;
        for (int i = 0; i < `SD_SECTOR_BYTES + 2; i++) begin
            @(posedge clk_sys);
            host_we <= 1'b0;
            if (i < `SD_SECTOR_BYTES) begin
                host_addr <= buf_addr_t'(i);
                if (!exp_write) begin
                    rng = xorshift(rng);
                    sector[i] = rng[7:0];
                    host_wdata <= rng[7:0];
                    host_we <= 1'b1;
                end
            end
            if (exp_write && i >= 2) check_byte("host_rdata", host_rdata, sector[i-2]);  // 2-deep pipe
        end
        @(posedge clk_sys) req_done <= 1'b1;
        @(posedge clk_sys) req_done <= 1'b0;
    endtask

    task automatic master_read();
        sd_byte_t b;
        int       n;
        n = 0;
        spi_byte(`SD_FILL, b);
        while (b != `SD_TOKEN_START) begin
            check_byte("sd_sdo fill", b, `SD_FILL);
            n++;
            if (n > 64) report_problem("read token never arrived");
            spi_byte(`SD_FILL, b);
        end
        for (int i = 0; i < `SD_SECTOR_BYTES; i++) begin
            spi_byte(`SD_FILL, b);
            check_byte("read data", b, sector[i]);
        end
        spi_byte(`SD_FILL, b);
        check_byte("read crc", b, `SD_FILL);
        spi_byte(`SD_FILL, b);
        check_byte("read crc", b, `SD_FILL);
    endtask

    task automatic master_write();
        sd_byte_t b;
        int       n;
        spi_byte(`SD_TOKEN_START, b);
        for (int i = 0; i < `SD_SECTOR_BYTES; i++) spi_byte(sector[i], b);
        spi_byte(8'hA5, b);  // crc bytes, any value
        spi_byte(8'h5A, b);
        spi_byte(`SD_FILL, b);
        check_byte("data response", b, `SD_DATA_RESP_OK);
        n = 0;
        spi_byte(`SD_FILL, b);
        while (b != `SD_FILL) begin  // busy until the host is done
            check_byte("write busy", b, 8'h00);
            n++;
            if (n > 64) report_problem("write busy never ended");
            spi_byte(`SD_FILL, b);
        end
    endtask

    task automatic read_block(input sd_arg_t arg, input int max_delay);
        exp_write = 1'b0;
        exp_lba = sdhc_mode ? arg : arg / `SD_SECTOR_BYTES;
        run_cmd(READ_SINGLE, arg, "CMD17");
        fork
            host_serve(max_delay);
            master_read();
        join
    endtask

    task automatic write_block(input sd_arg_t arg, input int max_delay);
        for (int i = 0; i < `SD_SECTOR_BYTES; i++) begin
            rng = xorshift(rng);
            sector[i] = rng[7:0];
        end
        exp_write = 1'b1;
        exp_lba = sdhc_mode ? arg : arg / `SD_SECTOR_BYTES;
        run_cmd(WRITE_SINGLE, arg, "CMD24");
        fork
            host_serve(max_delay);
            master_write();
        join
    endtask

    task automatic set_card_type(input logic hc);
        @(posedge clk_sys) sdhc_mode <= hc;
        @(posedge clk_sys);
    endtask

    // compares each accepted request
    always @(posedge clk_sys) begin
        if (req_valid && req_ready) begin
            check_lba(req_lba, exp_lba);
            if (req_write !== exp_write) report_mismatch("req_write", {31'd0, req_write},
                                                         {31'd0, exp_write});
        end
    end

    initial begin
        sector_init: for (int i = 0; i < `SD_SECTOR_BYTES; i++) sector[i] = 8'h00;
        card_is_reset = 1'b1;
        sd_cs = 1'b1;
        sd_sck = 1'b0;
        sd_sdi = 1'b1;
        req_ready = 1'b0;
        req_done = 1'b0;
        host_addr = '0;
        host_wdata = 8'h00;
        host_we = 1'b0;
        sdhc_mode = 1'b0;
        exp_write = 1'b0;
        exp_lba = '0;
        repeat (4) @(posedge clk_sys);
        card_is_reset <= 1'b0;
        @(posedge clk_sys) sd_cs <= 1'b0;
        repeat (4) @(posedge clk_sys);
        run_cmd(SEND_IF_COND, 32'h000001AA, "CMD8");  // uninitialized
        run_cmd(READ_SINGLE, 32'h0, "CMD17");
        run_cmd(GO_IDLE, 32'h0, "CMD0");
        run_cmd(SEND_IF_COND, 32'h000001A5, "CMD8");
        run_cmd(SD_SEND_OP_COND, 32'h40000000, "ACMD41");  // no CMD55 yet
        run_cmd(APP_CMD, 32'h0, "CMD55");
        run_cmd(SD_SEND_OP_COND, 32'h40000000, "ACMD41");
        run_cmd(READ_OCR, 32'h0, "CMD58");
        set_card_type(1'b1);
        run_cmd(READ_OCR, 32'h0, "CMD58");
        run_cmd(SEND_STATUS, 32'h0, "CMD13");
        run_cmd(SET_BLOCKLEN, 32'd512, "CMD16");
        run_cmd(SET_BLOCKLEN, 32'd1024, "CMD16");
        read_block(32'h00001234, 8);  // block address
        set_card_type(1'b0);
        read_block(32'h00046200, 8);  // byte address, lba 0x231
        write_block(32'h00000400, 8);
        set_card_type(1'b1);
        write_block(32'h00ABCDEF, 8);
        read_block(32'h00000077, 200);  // back-pressure
        write_block(32'h00000078, 200);
        $display("Test OK");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+hw
hw/sd_proto_pkg.sv
hw/sd_host_pkg.sv
hw/sd_spi_link.sv
hw/sd_card_regs.sv
hw/sd_cmd_engine.sv
hw/sd_block_xfer.sv
hw/sd_sector_buffer.sv
hw/sd_card_top.sv
dv/sd_card_props.sv
dv/sd_card_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = sd_card_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
